// File: include/lockstep_defines.svh
/* Lockstep checker sizes */
`ifndef LOCKSTEP_DEFINES_SVH
`define LOCKSTEP_DEFINES_SVH

// Data and PC width
`define LC_XLEN 32

// GPR address width, x0 to x31
`define LC_REG_AW 5

// Instruction and mismatch counters
`define LC_STAT_W 32

// Trap and halt skip counters, saturating
`define LC_SKIP_W 8

// Default instruction limit before the limit flag rises
`define LC_INSN_LIMIT 10000000

`endif

// File: source/lockstep_pkg.sv
/* Lockstep checker types */
`include "lockstep_defines.svh"

package lockstep_pkg;

    // One GPR writeback as reported at retirement
    typedef struct packed {
        logic                  we;
        logic [`LC_REG_AW-1:0] addr;
        logic [`LC_XLEN-1:0]   data;
    } gpr_wb_t;

    // Reference model retirement
    typedef struct packed {
        logic [`LC_XLEN-1:0] pc;
        gpr_wb_t             wb;
    } ref_retire_t;

    // Core retirement
    // bypass set when the core's writeback does not reflect this instruction
    typedef struct packed {
        logic [`LC_XLEN-1:0] pc;
        gpr_wb_t             wb;
        logic                bypass;
    } dut_retire_t;

    // Outcome of one compare
    // pc carries the core's retired PC
    typedef struct packed {
        logic                pc_err;
        logic                reg_err;
        logic [`LC_XLEN-1:0] pc;
    } check_result_t;

endpackage

// File: source/clknrst_if.sv
/* Checker clock interface */
interface clknrst_if;

    // Checker clock, driven by the environment
    logic clk;

    // Consumer view used by every checker block
    modport mon (
        input clk
    );

endinterface

// File: source/step_ctrl.sv
/* Lockstep step sequencer */
`include "lockstep_defines.svh"

module step_ctrl (
    clknrst_if.mon clknrst,
    input  logic   rst_n_i,
    input  logic   dut_retire_i,
    input  logic   dut_trap_i,
    input  logic   dut_halt_i,
    input  logic   ref_retire_i,
    input  logic   ref_trap_i,
    input  logic   ref_halt_i,
    output logic   dut_run_o,
    output logic   ref_step_o,
    output logic   dut_arm_o,
    output logic   ref_arm_o,
    output logic   cmp_go_o
);

    typedef enum logic [2:0] {
        IDLE,
        DUT_STEP,
        REF_ISSUE,
        REF_STEP,
        CMP
    } state_e;

    state_e state_q;
    state_e state_d;

    // Output flops, decoded from the next state
    logic in_dut_q;
    logic in_issue_q;
    logic in_ref_q;
    logic in_cmp_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: state_d = DUT_STEP;
            DUT_STEP: begin
                // Trap or halt keeps the core running for another try
                if (dut_trap_i || dut_halt_i)
                    state_d = DUT_STEP;
                else if (dut_retire_i)
                    state_d = REF_ISSUE;
            end
            // Single cycle step request
            REF_ISSUE: state_d = REF_STEP;
            REF_STEP: begin
                // Reissue the reference step on trap or halt
                if (ref_trap_i || ref_halt_i)
                    state_d = REF_ISSUE;
                else if (ref_retire_i)
                    state_d = CMP;
            end
            CMP: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clknrst.clk) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            in_dut_q   <= 1'b0;
            in_issue_q <= 1'b0;
            in_ref_q   <= 1'b0;
            in_cmp_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            in_dut_q   <= (state_d == DUT_STEP);
            in_issue_q <= (state_d == REF_ISSUE);
            in_ref_q   <= (state_d == REF_STEP);
            in_cmp_q   <= (state_d == CMP);
        end
    end

    // Core runs only while its step is open, and its latch is armed then
    assign dut_run_o  = in_dut_q;
    assign dut_arm_o  = in_dut_q;
    assign ref_step_o = in_issue_q;
    assign ref_arm_o  = in_ref_q;
    assign cmp_go_o   = in_cmp_q;

endmodule

// File: source/retire_latch.sv
/* Retirement record capture */
`include "lockstep_defines.svh"

module retire_latch #(
    parameter type payload_t = lockstep_pkg::ref_retire_t
) (
    clknrst_if.mon               clknrst,
    input  logic                 rst_n_i,
    input  logic                 arm_i,
    input  logic                 retire_i,
    input  logic                 trap_i,
    input  logic                 halt_i,
    input  payload_t             retire_data_i,
    output payload_t             record_o,
    output logic [`LC_SKIP_W-1:0] skip_count_o
);

    payload_t              record_q;
    logic [`LC_SKIP_W-1:0] skip_q;
    // Trap and halt may land together, so up to two per cycle
    logic [1:0]            skip_inc;
    // One spare bit to catch overflow
    logic [`LC_SKIP_W:0]   skip_sum;

    // Record is taken on the retire edge while armed
    always_ff @(posedge clknrst.clk) begin
        if (arm_i && retire_i) begin
            record_q <= retire_data_i;
        end
    end

    assign skip_inc = {1'b0, arm_i & trap_i} + {1'b0, arm_i & halt_i};
    assign skip_sum = {1'b0, skip_q} + {{(`LC_SKIP_W-1){1'b0}}, skip_inc};

    // Saturates at all ones instead of wrapping
    always_ff @(posedge clknrst.clk) begin
        if (!rst_n_i) begin
            skip_q <= '0;
        end else if (skip_sum[`LC_SKIP_W]) begin
            skip_q <= '1;
        end else begin
            skip_q <= skip_sum[`LC_SKIP_W-1:0];
        end
    end

    assign record_o     = record_q;
    assign skip_count_o = skip_q;

endmodule

// File: source/retire_compare.sv
/* Retirement record compare */
`include "lockstep_defines.svh"

module retire_compare (
    clknrst_if.mon                      clknrst,
    input  logic                        rst_n_i,
    input  logic                        cmp_go_i,
    input  lockstep_pkg::dut_retire_t   dut_rec_i,
    input  lockstep_pkg::ref_retire_t   ref_rec_i,
    output logic                        check_valid_o,
    output lockstep_pkg::check_result_t check_result_o
);

    import lockstep_pkg::*;

    gpr_wb_t       dut_wb;
    gpr_wb_t       ref_wb;
    logic          dut_eff;
    logic          ref_eff;
    logic          pc_err;
    logic          reg_err;
    logic          valid_q;
    check_result_t result_q;

    assign dut_wb = dut_rec_i.wb;
    assign ref_wb = ref_rec_i.wb;

    // Writes to x0 have no architectural effect
    assign dut_eff = dut_wb.we && (dut_wb.addr != '0);
    assign ref_eff = ref_wb.we && (ref_wb.addr != '0);

    assign pc_err = (dut_rec_i.pc != ref_rec_i.pc);

    always_comb begin
        reg_err = 1'b0;
        // Bypassed writeback tells nothing about this instruction
        if (!dut_rec_i.bypass) begin
            if (dut_eff != ref_eff) begin
                // Write seen on one side only
                reg_err = 1'b1;
            end else if (dut_eff) begin
                reg_err = (dut_wb.addr != ref_wb.addr) || (dut_wb.data != ref_wb.data);
            end
        end
    end

    always_ff @(posedge clknrst.clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cmp_go_i;
        end
    end

    // Result held until the next compare
    always_ff @(posedge clknrst.clk) begin
        if (cmp_go_i) begin
            result_q.pc_err  <= pc_err;
            result_q.reg_err <= reg_err;
            result_q.pc      <= dut_rec_i.pc;
        end
    end

    assign check_valid_o  = valid_q;
    assign check_result_o = result_q;

endmodule

// File: source/check_stats.sv
/* Compare statistics */
`include "lockstep_defines.svh"

module check_stats #(
    parameter int unsigned insn_limit = `LC_INSN_LIMIT
) (
    clknrst_if.mon                      clknrst,
    input  logic                        rst_n_i,
    input  logic                        check_valid_i,
    input  lockstep_pkg::check_result_t check_result_i,
    output logic [`LC_STAT_W-1:0]       insn_count_o,
    output logic [`LC_STAT_W-1:0]       mismatch_count_o,
    output logic                        limit_o,
    output logic [`LC_XLEN-1:0]         first_bad_pc_o
);

    logic [`LC_STAT_W-1:0] insn_q;
    logic [`LC_STAT_W-1:0] insn_next;
    logic [`LC_STAT_W-1:0] bad_q;
    logic                  limit_q;
    // Set once the first failing PC is held
    logic                  seen_bad_q;
    logic [`LC_XLEN-1:0]   bad_pc_q;
    logic                  is_bad;

    assign insn_next = insn_q + 1'b1;
    assign is_bad    = check_result_i.pc_err | check_result_i.reg_err;

    always_ff @(posedge clknrst.clk) begin
        if (!rst_n_i) begin
            insn_q     <= '0;
            bad_q      <= '0;
            limit_q    <= 1'b0;
            seen_bad_q <= 1'b0;
            bad_pc_q   <= '0;
        end else if (check_valid_i) begin
            insn_q <= insn_next;
            if (is_bad) begin
                bad_q <= bad_q + 1'b1;
            end
            // Only the first failure is kept
            if (is_bad && !seen_bad_q) begin
                seen_bad_q <= 1'b1;
                bad_pc_q   <= check_result_i.pc;
            end
            // Sticky, rises with the count that reaches the limit
            if (64'(insn_next) >= 64'(insn_limit)) begin
                limit_q <= 1'b1;
            end
        end
    end

    assign insn_count_o     = insn_q;
    assign mismatch_count_o = bad_q;
    assign limit_o          = limit_q;
    assign first_bad_pc_o   = bad_pc_q;

endmodule

// File: source/lockstep_checker.sv
/* Lockstep retirement checker */
`include "lockstep_defines.svh"

module lockstep_checker #(
    parameter int unsigned insn_limit = `LC_INSN_LIMIT
) (
    clknrst_if.mon                      clknrst,
    input  logic                        rst_n_i,
    // Core under test
    input  logic                        dut_retire_i,
    input  lockstep_pkg::dut_retire_t   dut_retire_data_i,
    input  logic                        dut_trap_i,
    input  logic                        dut_halt_i,
    // Reference model
    input  logic                        ref_retire_i,
    input  lockstep_pkg::ref_retire_t   ref_retire_data_i,
    input  logic                        ref_trap_i,
    input  logic                        ref_halt_i,
    // Step control
    output logic                        dut_run_o,
    output logic                        ref_step_o,
    // Per-step result
    output logic                        check_valid_o,
    output lockstep_pkg::check_result_t check_result_o,
    // Statistics
    output logic [`LC_SKIP_W-1:0]       dut_skip_count_o,
    output logic [`LC_SKIP_W-1:0]       ref_skip_count_o,
    output logic [`LC_STAT_W-1:0]       insn_count_o,
    output logic [`LC_STAT_W-1:0]       mismatch_count_o,
    output logic                        limit_o,
    output logic [`LC_XLEN-1:0]         first_bad_pc_o
);

    import lockstep_pkg::*;

    logic          dut_arm;
    logic          ref_arm;
    logic          cmp_go;
    dut_retire_t   dut_rec;
    ref_retire_t   ref_rec;
    check_result_t result;

    step_ctrl u_step_ctrl (
        .clknrst      (clknrst),
        .rst_n_i      (rst_n_i),
        .dut_retire_i (dut_retire_i),
        .dut_trap_i   (dut_trap_i),
        .dut_halt_i   (dut_halt_i),
        .ref_retire_i (ref_retire_i),
        .ref_trap_i   (ref_trap_i),
        .ref_halt_i   (ref_halt_i),
        .dut_run_o    (dut_run_o),
        .ref_step_o   (ref_step_o),
        .dut_arm_o    (dut_arm),
        .ref_arm_o    (ref_arm),
        .cmp_go_o     (cmp_go)
    );

    // Core side capture
    retire_latch #(.payload_t(dut_retire_t)) u_dut_latch (
        .clknrst       (clknrst),
        .rst_n_i       (rst_n_i),
        .arm_i         (dut_arm),
        .retire_i      (dut_retire_i),
        .trap_i        (dut_trap_i),
        .halt_i        (dut_halt_i),
        .retire_data_i (dut_retire_data_i),
        .record_o      (dut_rec),
        .skip_count_o  (dut_skip_count_o)
    );

    // Reference side capture
    retire_latch #(.payload_t(ref_retire_t)) u_ref_latch (
        .clknrst       (clknrst),
        .rst_n_i       (rst_n_i),
        .arm_i         (ref_arm),
        .retire_i      (ref_retire_i),
        .trap_i        (ref_trap_i),
        .halt_i        (ref_halt_i),
        .retire_data_i (ref_retire_data_i),
        .record_o      (ref_rec),
        .skip_count_o  (ref_skip_count_o)
    );

    retire_compare u_compare (
        .clknrst        (clknrst),
        .rst_n_i        (rst_n_i),
        .cmp_go_i       (cmp_go),
        .dut_rec_i      (dut_rec),
        .ref_rec_i      (ref_rec),
        .check_valid_o  (check_valid_o),
        .check_result_o (result)
    );

    check_stats #(.insn_limit(insn_limit)) u_stats (
        .clknrst          (clknrst),
        .rst_n_i          (rst_n_i),
        .check_valid_i    (check_valid_o),
        .check_result_i   (result),
        .insn_count_o     (insn_count_o),
        .mismatch_count_o (mismatch_count_o),
        .limit_o          (limit_o),
        .first_bad_pc_o   (first_bad_pc_o)
    );

    assign check_result_o = result;

endmodule

// File: tb/tb_clkgen.sv
/* Testbench clock and reset */
module tb_clkgen #(
    parameter int unsigned period       = 4,
    parameter int unsigned reset_cycles = 5
) (
    clknrst_if   clknrst,
    output logic rst_n_o
);

    // Free running clock, low at time zero
    initial begin
        clknrst.clk = 1'b0;
        forever #(period / 2) clknrst.clk = ~clknrst.clk;
    end

    // Reset released 1 unit after a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clknrst.clk);
        #1 rst_n_o = 1'b1;
    end

endmodule

// File: tb/lockstep_checker_tb.sv
/* Lockstep checker testbench */
`include "lockstep_defines.svh"

module lockstep_checker_tb;

    import lockstep_pkg::*;

    localparam int unsigned clk_period = 4;
    localparam int unsigned test_limit = 6;
    localparam int unsigned num_rows   = 11;
    localparam int unsigned max_delay  = 3;
    // Cycles for the worst row with every strobe after the longest delay
    localparam int unsigned row_cycles = 12 * (max_delay + 2);
    localparam int unsigned watchdog_time = (num_rows * row_cycles + 100) * clk_period;

    // One table row with 0 to 3 skips of each kind
    typedef struct packed {
        dut_retire_t dut_rec;
        ref_retire_t ref_rec;
        logic [1:0]  dut_traps;
        logic [1:0]  dut_halts;
        logic [1:0]  ref_traps;
        logic [1:0]  ref_halts;
    } row_t;

    clknrst_if clk_if ();
    logic rst_n;
    logic dut_retire_i;
    logic dut_trap_i;
    logic dut_halt_i;
    logic ref_retire_i;
    logic ref_trap_i;
    logic ref_halt_i;
    dut_retire_t dut_retire_data_i;
    ref_retire_t ref_retire_data_i;
    logic dut_run_o;
    logic ref_step_o;
    logic check_valid_o;
    logic limit_o;
    check_result_t check_result_o;
    logic [`LC_SKIP_W-1:0] dut_skip_count_o;
    logic [`LC_SKIP_W-1:0] ref_skip_count_o;
    logic [`LC_STAT_W-1:0] insn_count_o;
    logic [`LC_STAT_W-1:0] mismatch_count_o;
    logic [`LC_XLEN-1:0] first_bad_pc_o;

    row_t rows [num_rows];
    int seed;
    int unsigned error_count;
    // Expected statistics built up row by row
    logic [`LC_STAT_W-1:0] exp_insn;
    logic [`LC_STAT_W-1:0] exp_bad;
    logic [`LC_SKIP_W-1:0] exp_dut_skip;
    logic [`LC_SKIP_W-1:0] exp_ref_skip;
    logic [`LC_XLEN-1:0] exp_bad_pc;
    logic exp_seen_bad;

    tb_clkgen #(.period(clk_period), .reset_cycles(5)) u_clkgen (
        .clknrst (clk_if),
        .rst_n_o (rst_n)
    );

    lockstep_checker #(.insn_limit(test_limit)) UUT (
        .clknrst           (clk_if),
        .rst_n_i           (rst_n),
        .dut_retire_i      (dut_retire_i),
        .dut_retire_data_i (dut_retire_data_i),
        .dut_trap_i        (dut_trap_i),
        .dut_halt_i        (dut_halt_i),
        .ref_retire_i      (ref_retire_i),
        .ref_retire_data_i (ref_retire_data_i),
        .ref_trap_i        (ref_trap_i),
        .ref_halt_i        (ref_halt_i),
        .dut_run_o         (dut_run_o),
        .ref_step_o        (ref_step_o),
        .check_valid_o     (check_valid_o),
        .check_result_o    (check_result_o),
        .dut_skip_count_o  (dut_skip_count_o),
        .ref_skip_count_o  (ref_skip_count_o),
        .insn_count_o      (insn_count_o),
        .mismatch_count_o  (mismatch_count_o),
        .limit_o           (limit_o),
        .first_bad_pc_o    (first_bad_pc_o)
    );

    task automatic check_result(input check_result_t got, input check_result_t exp,
                                input string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s got pc_err=%b reg_err=%b pc=%h, expected %b %b %h",
                     $time, what, got.pc_err, got.reg_err, got.pc,
                     exp.pc_err, exp.reg_err, exp.pc);
            $display("Finished with errors");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_count(input logic [`LC_STAT_W-1:0] got,
                               input logic [`LC_STAT_W-1:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s got %0d, expected %0d", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_skip(input logic [`LC_SKIP_W-1:0] got,
                              input logic [`LC_SKIP_W-1:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s got %0d, expected %0d", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_pc(input logic [`LC_XLEN-1:0] got,
                            input logic [`LC_XLEN-1:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s got %b, expected %b", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // Expected compare outcome from the retirement rules
    function automatic check_result_t expected_result(input dut_retire_t d,
                                                      input ref_retire_t r);
        check_result_t e;
        logic core_writes;
        logic model_writes;
        core_writes  = d.wb.we && (d.wb.addr != 0);
        model_writes = r.wb.we && (r.wb.addr != 0);
        e.pc      = d.pc;
        e.pc_err  = (d.pc != r.pc);
        e.reg_err = 1'b0;
        if (!d.bypass && core_writes && model_writes)
            e.reg_err = (d.wb.addr != r.wb.addr) || (d.wb.data != r.wb.data);
        else if (!d.bypass)
            e.reg_err = core_writes ^ model_writes;
        return e;
    endfunction

    function automatic dut_retire_t core_record(input logic [`LC_XLEN-1:0] pc,
                                                input logic we,
                                                input logic [`LC_REG_AW-1:0] addr,
                                                input logic [`LC_XLEN-1:0] data,
                                                input logic bypass);
        dut_retire_t d;
        d.pc      = pc;
        d.wb.we   = we;
        d.wb.addr = addr;
        d.wb.data = data;
        d.bypass  = bypass;
        return d;
    endfunction

    function automatic ref_retire_t model_record(input logic [`LC_XLEN-1:0] pc,
                                                 input logic we,
                                                 input logic [`LC_REG_AW-1:0] addr,
                                                 input logic [`LC_XLEN-1:0] data);
        ref_retire_t r;
        r.pc      = pc;
        r.wb.we   = we;
        r.wb.addr = addr;
        r.wb.data = data;
        return r;
    endfunction

    // Skips packed as {dut traps, dut halts, ref traps, ref halts}
    task automatic set_row(input int idx, input dut_retire_t d, input ref_retire_t r,
                           input logic [7:0] skips);
        rows[idx] = '{dut_rec: d, ref_rec: r, dut_traps: skips[7:6], dut_halts: skips[5:4],
                      ref_traps: skips[3:2], ref_halts: skips[1:0]};
    endtask

    task automatic next_cycle();
        @(posedge clk_if.clk);
        #1;
    endtask

    task automatic pick_delay(output int unsigned d);
        d = $unsigned($random(seed)) % (max_delay + 1);
    endtask

    // One-cycle strobe on the core side
    task automatic strobe_core(input logic trap, input logic halt, input logic retire);
        dut_trap_i   = trap;
        dut_halt_i   = halt;
        dut_retire_i = retire;
        next_cycle();
        dut_trap_i   = 1'b0;
        dut_halt_i   = 1'b0;
        dut_retire_i = 1'b0;
    endtask

    // One-cycle strobe on the reference side
    task automatic strobe_model(input logic trap, input logic halt, input logic retire);
        ref_trap_i   = trap;
        ref_halt_i   = halt;
        ref_retire_i = retire;
        next_cycle();
        ref_trap_i   = 1'b0;
        ref_halt_i   = 1'b0;
        ref_retire_i = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        check_result_t exp;
        int unsigned dly;
        int unsigned n_dut;
        int unsigned n_ref;
        int unsigned k;
        exp   = expected_result(r.dut_rec, r.ref_rec);
        n_dut = r.dut_traps + r.dut_halts;
        n_ref = r.ref_traps + r.ref_halts;
        // No reference step may show up before the core retires
        while (!dut_run_o) begin
            check_flag(ref_step_o, 1'b0, "ref_step_o before core retirement");
            next_cycle();
        end
        for (k = 0; k <= n_dut; k++) begin
            pick_delay(dly);
            repeat (dly) begin
                next_cycle();
                check_flag(dut_run_o, 1'b1, "dut_run_o while waiting for the core");
            end
            // Trap and halt cycles carry junk data that must not be captured
            if (k < n_dut)
                dut_retire_data_i = ~r.dut_rec;
            else
                dut_retire_data_i = r.dut_rec;
            if (k < r.dut_traps)
                strobe_core(1'b1, 1'b0, 1'b0);
            else if (k < n_dut)
                strobe_core(1'b0, 1'b1, 1'b0);
            else
                strobe_core(1'b0, 1'b0, 1'b1);
            if (k < n_dut)
                check_flag(dut_run_o, 1'b1, "dut_run_o after core trap or halt");
        end
        check_flag(dut_run_o, 1'b0, "dut_run_o after core retirement");
        // Each reference trap or halt asks for a fresh step
        for (k = 0; k <= n_ref; k++) begin
            while (!ref_step_o)
                next_cycle();
            check_flag(dut_run_o, 1'b0, "dut_run_o during ref_step_o");
            next_cycle();
            check_flag(ref_step_o, 1'b0, "ref_step_o pulse width");
            pick_delay(dly);
            repeat (dly) next_cycle();
            if (k < n_ref)
                ref_retire_data_i = ~r.ref_rec;
            else
                ref_retire_data_i = r.ref_rec;
            if (k < r.ref_traps)
                strobe_model(1'b1, 1'b0, 1'b0);
            else if (k < n_ref)
                strobe_model(1'b0, 1'b1, 1'b0);
            else
                strobe_model(1'b0, 1'b0, 1'b1);
        end
        while (!check_valid_o)
            next_cycle();
        check_result(check_result_o, exp, "check_result_o");
        exp_insn++;
        exp_dut_skip += n_dut;
        exp_ref_skip += n_ref;
        if (exp.pc_err || exp.reg_err) begin
            exp_bad++;
            if (!exp_seen_bad)
                exp_bad_pc = exp.pc;
            exp_seen_bad = 1'b1;
        end
        // Statistics are visible one cycle after the result
        next_cycle();
        check_flag(check_valid_o, 1'b0, "check_valid_o pulse width");
        check_count(insn_count_o, exp_insn, "insn_count_o");
        check_count(mismatch_count_o, exp_bad, "mismatch_count_o");
        check_pc(first_bad_pc_o, exp_bad_pc, "first_bad_pc_o");
        check_skip(dut_skip_count_o, exp_dut_skip, "dut_skip_count_o");
        check_skip(ref_skip_count_o, exp_ref_skip, "ref_skip_count_o");
        check_flag(limit_o, exp_insn >= test_limit, "limit_o");
    endtask

    initial begin
        #(watchdog_time);
        $display("Timeout: the checker did not finish all table rows in time");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main
        int i;
        seed = 32'hd9836001;
        error_count = 0;
        {dut_retire_i, dut_trap_i, dut_halt_i} = 3'b000;
        {ref_retire_i, ref_trap_i, ref_halt_i} = 3'b000;
        dut_retire_data_i = '0;
        ref_retire_data_i = '0;
        exp_insn     = '0;
        exp_bad      = '0;
        exp_dut_skip = '0;
        exp_ref_skip = '0;
        exp_bad_pc   = '0;
        exp_seen_bad = 1'b0;
        // Matching, no writes, PC, data, address, one-sided write
        set_row(0, core_record(32'h100, 1'b1, 5'd1, 32'h11, 1'b0),
                model_record(32'h100, 1'b1, 5'd1, 32'h11), 8'b00_00_00_00);
        set_row(1, core_record(32'h104, 1'b0, 5'd0, 32'h0, 1'b0),
                model_record(32'h104, 1'b0, 5'd0, 32'h0), 8'b00_00_00_00);
        set_row(2, core_record(32'h108, 1'b1, 5'd2, 32'h22, 1'b0),
                model_record(32'h10c, 1'b1, 5'd2, 32'h22), 8'b00_00_00_00);
        set_row(3, core_record(32'h10c, 1'b1, 5'd3, 32'h33, 1'b0),
                model_record(32'h10c, 1'b1, 5'd3, 32'h34), 8'b00_00_00_00);
        set_row(4, core_record(32'h110, 1'b1, 5'd4, 32'h44, 1'b0),
                model_record(32'h110, 1'b1, 5'd5, 32'h44), 8'b00_00_00_00);
        set_row(5, core_record(32'h114, 1'b1, 5'd6, 32'h66, 1'b0),
                model_record(32'h114, 1'b0, 5'd6, 32'h66), 8'b00_00_01_01);
        // x0 writes and bypass mixed with traps and halts
        set_row(6, core_record(32'h118, 1'b1, 5'd0, 32'h77, 1'b0),
                model_record(32'h118, 1'b0, 5'd0, 32'h0), 8'b10_01_00_00);
        set_row(7, core_record(32'h11c, 1'b1, 5'd0, 32'h88, 1'b0),
                model_record(32'h11c, 1'b1, 5'd0, 32'h99), 8'b00_00_00_00);
        set_row(8, core_record(32'h120, 1'b1, 5'd7, 32'haa, 1'b1),
                model_record(32'h120, 1'b1, 5'd8, 32'hbb), 8'b01_00_10_00);
        set_row(9, core_record(32'h124, 1'b0, 5'd0, 32'h0, 1'b1),
                model_record(32'h128, 1'b1, 5'd9, 32'hcc), 8'b00_01_00_01);
        set_row(10, core_record(32'h128, 1'b1, 5'd31, 32'hff, 1'b0),
                model_record(32'h128, 1'b1, 5'd31, 32'hff), 8'b01_00_01_00);
        // Both step outputs stay idle in the middle of reset
        repeat (2) @(posedge clk_if.clk);
        #2;
        check_flag(dut_run_o, 1'b0, "dut_run_o in reset");
        check_flag(ref_step_o, 1'b0, "ref_step_o in reset");
        wait (rst_n == 1'b1);
        check_flag(dut_run_o, 1'b0, "dut_run_o after reset");
        check_flag(ref_step_o, 1'b0, "ref_step_o after reset");
        check_flag(check_valid_o, 1'b0, "check_valid_o after reset");
        for (i = 0; i < num_rows; i++)
            run_row(rows[i]);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: lockstep_checker.f
+incdir+include
source/lockstep_pkg.sv
source/clknrst_if.sv
source/step_ctrl.sv
source/retire_latch.sv
source/retire_compare.sv
source/check_stats.sv
source/lockstep_checker.sv
tb/tb_clkgen.sv
tb/lockstep_checker_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the lockstep checker testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f lockstep_checker.f \
    --top-module lockstep_checker_tb -o lockstep_sim \
    && ./obj_dir/lockstep_sim | tee /dev/stderr | grep -q "^Finished with no errors$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
